// ==== src/udp_echo_pkg.sv ====
// ----------------------------------------------------------------------
// shared definitions for the udp echo block:
// payload widths, header field types, the echo port number
// and the state encoding of the frame control FSM
// ----------------------------------------------------------------------

package udp_echo_pkg;

    // payload beat geometry
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    // header field widths
    localparam int IP_ADDR_W  = 32;
    localparam int UDP_PORT_W = 16;
    localparam int UDP_LEN_W  = 16;
    localparam int LED_W      = 2;

    // payload beat and its byte enables
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [KEEP_W-1:0] keep_t;

    // header fields
    typedef logic [IP_ADDR_W-1:0]  ip_addr_t;
    typedef logic [UDP_PORT_W-1:0] udp_port_t;
    typedef logic [UDP_LEN_W-1:0]  udp_len_t;

    // board status lights
    typedef logic [LED_W-1:0] led_t;

    // frames to this destination port are answered
    localparam udp_port_t ECHO_PORT = 16'd1234;

    // frame control states
    //   IDLE  waiting for the next header
    //   FWD   payload of a matching frame is forwarded
    //   DROP  payload of any other frame is discarded
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        FWD  = 2'd1,
        DROP = 2'd2
    } echo_state_t;

endpackage

// ==== src/echo_ctrl.sv ====
// ----------------------------------------------------------------------
// frame control FSM
// accepts one header at a time, compares its destination port
// with the echo port and steers the payload path to forward or drop
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module echo_ctrl import udp_echo_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  logic      in_hdr_valid,
    input  udp_port_t in_dst_port,
    input  logic      out_hdr_valid,
    input  logic      frame_end,

    output logic      in_hdr_ready,
    output logic      hdr_load,
    output logic      pass,
    output logic      drop
);

    echo_state_t state;
    echo_state_t state_next;

    logic hdr_fire;
    logic port_match;

    // a new header is taken only once the previous reply has left,
    // so the reply register is never overwritten while pending
    assign in_hdr_ready = (state == IDLE) && !out_hdr_valid;
    assign hdr_fire     = in_hdr_valid && in_hdr_ready;

    assign port_match = (in_dst_port == ECHO_PORT);

    // capture reply fields on the same edge the header is taken
    assign hdr_load = hdr_fire && port_match;

    assign pass = (state == FWD);
    assign drop = (state == DROP);

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (hdr_fire) begin
                    if (port_match) begin
                        state_next = FWD;
                    end else begin
                        state_next = DROP;
                    end
                end
            end
            FWD: begin
                if (frame_end) begin
                    state_next = IDLE;
                end
            end
            DROP: begin
                if (frame_end) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== src/reply_hdr_build.sv ====
// ----------------------------------------------------------------------
// reply header register
// swaps the udp ports, returns to the sender ip and holds the
// header valid until the downstream takes it
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module reply_hdr_build import udp_echo_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  logic      hdr_load,
    input  ip_addr_t  in_src_ip,
    input  udp_port_t in_src_port,
    input  udp_port_t in_dst_port,
    input  udp_len_t  in_length,

    input  logic      out_hdr_ready,
    output logic      out_hdr_valid,
    output ip_addr_t  out_dst_ip,
    output udp_port_t out_src_port,
    output udp_port_t out_dst_port,
    output udp_len_t  out_length
);

    // valid flag
    // hdr_load never arrives while a reply is still pending
    always_ff @(posedge clk) begin
        if (rst) begin
            out_hdr_valid <= 1'b0;
        end else if (hdr_load) begin
            out_hdr_valid <= 1'b1;
        end else if (out_hdr_ready) begin
            out_hdr_valid <= 1'b0;
        end
    end

    // reply fields
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            // answer goes back to whoever sent it
            out_dst_ip   <= in_src_ip;
            out_src_port <= in_dst_port;
            out_dst_port <= in_src_port;
            out_length   <= in_length;
        end
    end

endmodule

// ==== src/payload_path.sv ====
// ----------------------------------------------------------------------
// payload path
// two-entry skid buffer with drop gating, frame end detection
// and capture of the first forwarded beat onto the LEDs
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module payload_path import udp_echo_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  pass,
    input  logic  drop,

    input  logic  in_valid,
    input  data_t in_data,
    input  keep_t in_keep,
    input  logic  in_last,
    input  logic  in_user,
    input  logic  out_ready,

    output logic  in_ready,
    output logic  out_valid,
    output data_t out_data,
    output keep_t out_keep,
    output logic  out_last,
    output logic  out_user,
    output logic  frame_end,
    output led_t  led
);

    // buffer storage
    data_t data_mem [2];
    keep_t keep_mem [2];
    logic  last_mem [2];
    logic  user_mem [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       full;
    logic       in_fire;
    logic       push;
    logic       pop;
    logic       first_beat;

    assign full      = (count == 2'd2);
    assign in_ready  = drop || (pass && !full);
    assign in_fire   = in_valid && in_ready;
    assign push      = in_fire && pass;
    assign pop       = out_valid && out_ready;
    assign frame_end = in_fire && in_last;

    assign out_valid = (count != 2'd0);
    assign out_data  = data_mem[rd_ptr];
    assign out_keep  = keep_mem[rd_ptr];
    assign out_last  = last_mem[rd_ptr];
    assign out_user  = user_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= in_data;
            keep_mem[wr_ptr] <= in_keep;
            last_mem[wr_ptr] <= in_last;
            user_mem[wr_ptr] <= in_user;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            if (push && !pop) begin
                count <= count + 2'd1;
            end else if (pop && !push) begin
                count <= count - 2'd1;
            end
        end
    end

    // next accepted beat opens a frame after every last beat,
    // dropped frames included
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= '0;
        end else if (in_fire) begin
            first_beat <= in_last;
            if (first_beat && pass) begin
                led <= in_data[LED_W-1:0];
            end
        end
    end

endmodule

// ==== src/udp_echo_top.sv ====
// ----------------------------------------------------------------------
// udp echo top level
// connects the frame control FSM, the reply header register
// and the payload skid buffer
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module udp_echo_top import udp_echo_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // parsed udp header in
    input  logic      in_hdr_valid,
    output logic      in_hdr_ready,
    input  ip_addr_t  in_src_ip,
    input  udp_port_t in_src_port,
    input  udp_port_t in_dst_port,
    input  udp_len_t  in_length,

    // payload in
    input  logic      in_valid,
    output logic      in_ready,
    input  data_t     in_data,
    input  keep_t     in_keep,
    input  logic      in_last,
    input  logic      in_user,

    // reply header out
    output logic      out_hdr_valid,
    input  logic      out_hdr_ready,
    output ip_addr_t  out_dst_ip,
    output udp_port_t out_src_port,
    output udp_port_t out_dst_port,
    output udp_len_t  out_length,

    // payload out
    output logic      out_valid,
    input  logic      out_ready,
    output data_t     out_data,
    output keep_t     out_keep,
    output logic      out_last,
    output logic      out_user,

    output led_t      led
);

    logic hdr_load;
    logic pass;
    logic drop;
    logic frame_end;

    echo_ctrl i_echo_ctrl (
        .clk           (clk),
        .rst           (rst),
        .in_hdr_valid  (in_hdr_valid),
        .in_dst_port   (in_dst_port),
        .out_hdr_valid (out_hdr_valid),
        .frame_end     (frame_end),
        .in_hdr_ready  (in_hdr_ready),
        .hdr_load      (hdr_load),
        .pass          (pass),
        .drop          (drop)
    );

    reply_hdr_build i_reply_hdr_build (
        .clk           (clk),
        .rst           (rst),
        .hdr_load      (hdr_load),
        .in_src_ip     (in_src_ip),
        .in_src_port   (in_src_port),
        .in_dst_port   (in_dst_port),
        .in_length     (in_length),
        .out_hdr_ready (out_hdr_ready),
        .out_hdr_valid (out_hdr_valid),
        .out_dst_ip    (out_dst_ip),
        .out_src_port  (out_src_port),
        .out_dst_port  (out_dst_port),
        .out_length    (out_length)
    );

    payload_path i_payload_path (
        .clk       (clk),
        .rst       (rst),
        .pass      (pass),
        .drop      (drop),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_last   (in_last),
        .in_user   (in_user),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_last  (out_last),
        .out_user  (out_user),
        .frame_end (frame_end),
        .led       (led)
    );

endmodule

// ==== dv/clk_gen.sv ====
// ----------------------------------------------------------------------
// testbench clock and reset source
// 40 ns clock, reset held over the first three rising edges
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    // released on the falling edge like every other DUT input
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== dv/tb_udp_echo.sv ====
// ----------------------------------------------------------------------
// testbench for the udp echo block
// random frames from an LCG, queue based reference model,
// per cycle checks of reply headers, payload beats and LEDs
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_udp_echo import udp_echo_pkg::*; ();

    localparam int SEED          = 4461;
    localparam int PLAIN_FRAMES  = 20;
    localparam int STALL_FRAMES  = 40;
    localparam int RESET_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 8000;

    typedef struct packed {
        ip_addr_t  ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
    } hdr_t;

    // match and first are model side tags, not sent to the DUT
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
        logic  first;
        logic  match;
    } beat_t;

    logic      clk;
    logic      rst;
    logic      in_hdr_valid;
    logic      in_hdr_ready;
    ip_addr_t  in_src_ip;
    udp_port_t in_src_port;
    udp_port_t in_dst_port;
    udp_len_t  in_length;
    logic      in_valid;
    logic      in_ready;
    data_t     in_data;
    keep_t     in_keep;
    logic      in_last;
    logic      in_user;
    logic      out_hdr_valid;
    logic      out_hdr_ready;
    ip_addr_t  out_dst_ip;
    udp_port_t out_src_port;
    udp_port_t out_dst_port;
    udp_len_t  out_length;
    logic      out_valid;
    logic      out_ready;
    data_t     out_data;
    keep_t     out_keep;
    logic      out_last;
    logic      out_user;
    led_t      led;

    // stimulus still to be sent and replies still expected
    hdr_t  hdr_in_q[$];
    beat_t beat_in_q[$];
    hdr_t  exp_hdr_q[$];
    beat_t exp_beat_q[$];

    logic [31:0] rng_state;
    led_t        exp_led;
    logic        hdr_taken;
    logic        beat_taken;
    logic        hdr_loaded_prev;
    logic        beat_fwd_prev;
    int          frames_echoed;
    int          frames_dropped;

    clk_gen i_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    udp_echo_top i_udp_echo_top (
        .clk           (clk),
        .rst           (rst),
        .in_hdr_valid  (in_hdr_valid),
        .in_hdr_ready  (in_hdr_ready),
        .in_src_ip     (in_src_ip),
        .in_src_port   (in_src_port),
        .in_dst_port   (in_dst_port),
        .in_length     (in_length),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_data       (in_data),
        .in_keep       (in_keep),
        .in_last       (in_last),
        .in_user       (in_user),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_dst_ip    (out_dst_ip),
        .out_src_port  (out_src_port),
        .out_dst_port  (out_dst_port),
        .out_length    (out_length),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .out_keep      (out_keep),
        .out_last      (out_last),
        .out_user      (out_user),
        .led           (led)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // low bits of an LCG are weak, so use the upper ones
    function automatic int rand_below(input int n);
        return int'((next_random() >> 8) % n);
    endfunction

    function automatic logic traffic_done();
        return hdr_in_q.size() == 0 && beat_in_q.size() == 0 &&
               exp_hdr_q.size() == 0 && exp_beat_q.size() == 0 &&
               !in_hdr_valid && !in_valid;
    endfunction

    task automatic check_failed(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic timed_out(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("Test FAILED");
        $fatal(1, "stopped after timeout");
    endtask

    // one frame into the stimulus queues, echo replies into the model
    task automatic make_frame();
        hdr_t      h;
        hdr_t      r;
        beat_t     b;
        udp_port_t other_port;
        int        nbeats;
        logic      match;
        match      = (rand_below(2) == 1);
        other_port = udp_port_t'(next_random());
        if (other_port == ECHO_PORT) begin
            other_port = other_port + 16'd1;
        end
        nbeats     = 1 + rand_below(8);
        h.ip       = ip_addr_t'(next_random());
        h.src_port = udp_port_t'(next_random());
        h.dst_port = match ? ECHO_PORT : other_port;
        h.length   = udp_len_t'(8 + 8 * nbeats);
        hdr_in_q.push_back(h);
        if (match) begin
            r.ip       = h.ip;
            r.src_port = h.dst_port;
            r.dst_port = h.src_port;
            r.length   = h.length;
            exp_hdr_q.push_back(r);
            frames_echoed++;
        end else begin
            frames_dropped++;
        end
        for (int i = 0; i < nbeats; i++) begin
            b.data  = data_t'({next_random(), next_random()});
            b.keep  = keep_t'(next_random());
            b.last  = (i == nbeats - 1);
            b.user  = (rand_below(2) == 1);
            b.first = (i == 0);
            b.match = match;
            beat_in_q.push_back(b);
            if (match) begin
                exp_beat_q.push_back(b);
            end
        end
    endtask

    // called right after the falling edge
    task automatic drive_inputs(input logic bp);
        if (hdr_taken) begin
            in_hdr_valid = 1'b0;
            hdr_taken    = 1'b0;
        end
        if (beat_taken) begin
            in_valid   = 1'b0;
            beat_taken = 1'b0;
        end
        if (!in_hdr_valid && hdr_in_q.size() > 0 && rand_below(3) == 0) begin
            in_hdr_valid = 1'b1;
            in_src_ip    = hdr_in_q[0].ip;
            in_src_port  = hdr_in_q[0].src_port;
            in_dst_port  = hdr_in_q[0].dst_port;
            in_length    = hdr_in_q[0].length;
        end
        if (!in_valid && beat_in_q.size() > 0 && rand_below(4) != 0) begin
            in_valid = 1'b1;
            in_data  = beat_in_q[0].data;
            in_keep  = beat_in_q[0].keep;
            in_last  = beat_in_q[0].last;
            in_user  = beat_in_q[0].user;
        end
        out_hdr_ready = bp ? (rand_below(3) != 0) : 1'b1;
        out_ready     = bp ? (rand_below(2) == 0) : 1'b1;
    endtask

    // sees the handshakes that complete on the coming rising edge
    task automatic check_cycle(input logic bp);
        hdr_t  h;
        beat_t b;
        assert (led == exp_led)
            else check_failed($sformatf("led is %0d, expected %0d", led, exp_led));
        if (hdr_loaded_prev) begin
            assert (out_hdr_valid)
                else check_failed("no reply header one cycle after an echo header");
        end
        if (beat_fwd_prev && !bp) begin
            assert (out_valid)
                else check_failed("forwarded beat missing one cycle after acceptance");
        end
        hdr_loaded_prev = 1'b0;
        beat_fwd_prev   = 1'b0;
        if (out_hdr_valid && out_hdr_ready) begin
            assert (exp_hdr_q.size() > 0)
                else check_failed("reply header without a pending echo frame");
            h = exp_hdr_q.pop_front();
            assert (out_dst_ip == h.ip)
                else check_failed($sformatf("dst ip %h, expected %h", out_dst_ip, h.ip));
            assert (out_src_port == h.src_port)
                else check_failed($sformatf("src port %0d, expected %0d",
                                            out_src_port, h.src_port));
            assert (out_dst_port == h.dst_port)
                else check_failed($sformatf("dst port %0d, expected %0d",
                                            out_dst_port, h.dst_port));
            assert (out_length == h.length)
                else check_failed($sformatf("length %0d, expected %0d", out_length, h.length));
        end
        if (out_valid && out_ready) begin
            assert (exp_beat_q.size() > 0)
                else check_failed("output beat with none expected");
            b = exp_beat_q.pop_front();
            assert ({out_data, out_keep, out_last, out_user} == {b.data, b.keep, b.last, b.user})
                else check_failed($sformatf("beat %h/%h/%b/%b, expected %h/%h/%b/%b",
                                            out_data, out_keep, out_last, out_user,
                                            b.data, b.keep, b.last, b.user));
        end
        if (in_hdr_valid && in_hdr_ready) begin
            h               = hdr_in_q.pop_front();
            hdr_loaded_prev = (h.dst_port == ECHO_PORT);
            hdr_taken       = 1'b1;
        end
        if (in_valid && in_ready) begin
            b = beat_in_q.pop_front();
            if (b.match && b.first) begin
                exp_led = b.data[LED_W-1:0];
            end
            beat_fwd_prev = b.match;
            beat_taken    = 1'b1;
        end
    endtask

    task automatic run_phase(input int frames, input logic bp);
        int cycles;
        for (int i = 0; i < frames; i++) begin
            make_frame();
        end
        cycles = 0;
        while (!traffic_done()) begin
            @(negedge clk);
            drive_inputs(bp);
            #1;
            check_cycle(bp);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                timed_out("frames did not drain through the DUT");
            end
        end
    endtask

    initial begin
        int cycles;
        rng_state       = SEED;
        in_hdr_valid    = 1'b0;
        in_src_ip       = '0;
        in_src_port     = '0;
        in_dst_port     = '0;
        in_length       = '0;
        in_valid        = 1'b0;
        in_data         = '0;
        in_keep         = '0;
        in_last         = 1'b0;
        in_user         = 1'b0;
        out_hdr_ready   = 1'b0;
        out_ready       = 1'b0;
        exp_led         = '0;
        hdr_taken       = 1'b0;
        beat_taken      = 1'b0;
        hdr_loaded_prev = 1'b0;
        beat_fwd_prev   = 1'b0;
        frames_echoed   = 0;
        frames_dropped  = 0;
        cycles          = 0;
        do begin
            @(negedge clk);
            #1;
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                timed_out("reset was never released");
            end
        end while (rst !== 1'b0);
        assert (!out_hdr_valid && !out_valid && led == '0)
            else check_failed("outputs not idle after reset");
        // full throughput first, then random stalls on both outputs
        run_phase(PLAIN_FRAMES, 1'b0);
        run_phase(STALL_FRAMES, 1'b1);
        // the last output handshakes complete on the next rising edge
        @(negedge clk);
        #1;
        assert (!out_hdr_valid && !out_valid)
            else check_failed("output still valid after all frames");
        $display("%0d frames echoed, %0d frames dropped", frames_echoed, frames_dropped);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== udp_echo.f ====
src/udp_echo_pkg.sv
src/echo_ctrl.sv
src/reply_hdr_build.sv
src/payload_path.sv
src/udp_echo_top.sv
dv/clk_gen.sv
dv/tb_udp_echo.sv

// ==== Makefile ====
# Verilator build and run for the udp echo block

VERILATOR  ?= verilator
TOP        := tb_udp_echo
FILELIST   := udp_echo.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
SOURCES    := $(wildcard src/*.sv) $(wildcard dv/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
